//--- common/cpuPkg.sv
package cpuPkg;

    // Register address width, eight registers
    localparam int regAddrW = 3;

    // JAL and JALR write their return address here
    localparam logic [regAddrW-1:0] linkReg = 3'd7;

    // Opcode sits in the top five bits of every format
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;

    // Register fields, each regAddrW bits wide, given by their low bit
    // First field: write destination, source for branches, JR/JALR and SLBI,
    // base address for ST
    localparam int reg1Lsb = 24;
    // Second field: first ALU source for R-type, IType1 and LD, store data for ST
    localparam int reg2Lsb = 21;
    // Third field: second ALU source, R-type only
    localparam int reg3Lsb = 18;

    // IType1 immediate widths
    localparam int imm1SignedW = 19;
    localparam int imm1ZeroW   = 20;

    // IType2 immediate widths
    localparam int imm2SignedW = 23;
    localparam int slbiImmW    = 16;

    // Signed displacement of J and JAL
    localparam int jumpDispW = 27;

    typedef enum logic [4:0] {
        opNop  = 5'h00,
        opHalt = 5'h01,
        // R-type
        opAdd  = 5'h02,
        opSub  = 5'h03,
        opAnd  = 5'h04,
        opOr   = 5'h05,
        opXor  = 5'h06,
        opSll  = 5'h07,
        opSrl  = 5'h08,
        opSlt  = 5'h09,
        // IType1
        opAddi = 5'h0a,
        opAndi = 5'h0b,
        opOri  = 5'h0c,
        opXori = 5'h0d,
        opLd   = 5'h0e,
        opSt   = 5'h0f,
        // IType2
        opSlbi = 5'h10,
        opBeqz = 5'h11,
        opBnez = 5'h12,
        opBltz = 5'h13,
        opBgez = 5'h14,
        opJr   = 5'h15,
        opJalr = 5'h16,
        // Jump
        opJ    = 5'h17,
        opJal  = 5'h18
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd   = 4'h0,
        aluSub   = 4'h1,
        aluAnd   = 4'h2,
        aluOr    = 4'h3,
        aluXor   = 4'h4,
        aluSll   = 4'h5,
        aluSrl   = 4'h6,
        aluSlt   = 4'h7,
        aluPassB = 4'h8,
        aluSlbi  = 4'h9,
        // Compares against zero, only isTaken matters
        aluEqz   = 4'ha,
        aluNez   = 4'hb,
        aluLtz   = 4'hc,
        aluGez   = 4'hd
    } aluOpE;

endpackage

//--- design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  opcodeE opcode,
    output logic   isSignExtend,
    output logic   isIType1,
    output logic   isBranch,
    output logic   aluSrc,
    output logic   isJump,
    output logic   isJR,
    output logic   isSLBI,
    output aluOpE  aluOp,
    output logic   regWrite,
    output logic   memWrite,
    output logic   memToReg,
    output logic   isLink,
    output logic   isHalt
);

    always_comb begin
        // Everything idles unless the opcode says otherwise
        isSignExtend = 1'b0;
        isIType1     = 1'b0;
        isBranch     = 1'b0;
        aluSrc       = 1'b0;
        isJump       = 1'b0;
        isJR         = 1'b0;
        isSLBI       = 1'b0;
        aluOp        = aluPassB;
        regWrite     = 1'b0;
        memWrite     = 1'b0;
        memToReg     = 1'b0;
        isLink       = 1'b0;
        isHalt       = 1'b0;

        case (opcode)
            // R-type, B input is the third register
            opAdd, opSub, opAnd, opOr, opXor, opSll, opSrl, opSlt: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                case (opcode)
                    opSub:   aluOp = aluSub;
                    opAnd:   aluOp = aluAnd;
                    opOr:    aluOp = aluOr;
                    opXor:   aluOp = aluXor;
                    opSll:   aluOp = aluSll;
                    opSrl:   aluOp = aluSrl;
                    opSlt:   aluOp = aluSlt;
                    default: aluOp = aluAdd;
                endcase
            end
            // ADDI sign extends, the logic immediates zero extend
            opAddi: begin
                isIType1     = 1'b1;
                isSignExtend = 1'b1;
                aluOp        = aluAdd;
                regWrite     = 1'b1;
            end
            opAndi, opOri, opXori: begin
                isIType1 = 1'b1;
                regWrite = 1'b1;
                aluOp    = (opcode == opAndi) ? aluAnd :
                           (opcode == opOri)  ? aluOr  : aluXor;
            end
            // Address is register plus signed offset for both
            opLd, opSt: begin
                isIType1     = 1'b1;
                isSignExtend = 1'b1;
                aluOp        = aluAdd;
                regWrite     = (opcode == opLd);
                memToReg     = (opcode == opLd);
                memWrite     = (opcode == opSt);
            end
            opSlbi: begin
                isSLBI   = 1'b1;
                aluOp    = aluSlbi;
                regWrite = 1'b1;
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                isBranch = 1'b1;
                aluOp    = (opcode == opBeqz) ? aluEqz :
                           (opcode == opBnez) ? aluNez :
                           (opcode == opBltz) ? aluLtz : aluGez;
            end
            // Target comes out of the ALU as register plus immediate
            opJr, opJalr: begin
                isJR     = 1'b1;
                aluOp    = aluAdd;
                regWrite = (opcode == opJalr);
                isLink   = (opcode == opJalr);
            end
            opJ, opJal: begin
                isJump   = 1'b1;
                regWrite = (opcode == opJal);
                isLink   = (opcode == opJal);
            end
            opHalt: isHalt = 1'b1;
            // NOP and unknown opcodes keep the defaults
            default: ;
        endcase
    end

    // Execute stage would add two different offsets if both were set
    always_comb begin
        assert (!(isJump && isBranch))
            else $error("controlUnit: jump and branch decoded together");
    end

endmodule

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic [regAddrW-1:0] rdAddr1,
    input  logic [regAddrW-1:0] rdAddr2,
    input  logic                wrEn,
    input  logic [regAddrW-1:0] wrAddr,
    input  logic [31:0]         wrData,
    output logic [31:0]         rdData1,
    output logic [31:0]         rdData2
);

    logic [31:0] regs [2**regAddrW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        // Register 0 is hardwired, drop any write to it
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads see the value from before this cycle's write
    assign rdData1 = regs[rdAddr1];
    assign rdData2 = regs[rdAddr2];

    // Zero register must hold across every write the core issues
    assert property (@(posedge clk) disable iff (!rstN) regs[0] == '0)
        else $error("regFile: register 0 is not zero");

endmodule

//--- execute/claAdder32.sv
`timescale 1ns/1ps

module claAdder32 (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic        cin,
    output logic [31:0] sum
);

    // Group generate and propagate, the top group feeds no carry
    logic [6:0] grpG;
    logic [6:0] grpP;
    logic [7:0] grpCarry;

    for (genvar gi = 0; gi < 8; gi++) begin : gGroup
        logic [3:0] g;
        logic [3:0] p;
        logic [3:0] c;

        assign g = a[gi*4 +: 4] & b[gi*4 +: 4];
        assign p = a[gi*4 +: 4] ^ b[gi*4 +: 4];

        // Bit carries inside the group, fully expanded
        assign c[0] = grpCarry[gi];
        assign c[1] = g[0] | (p[0] & c[0]);
        assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
        assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
                      (p[2] & p[1] & p[0] & c[0]);

        assign sum[gi*4 +: 4] = p ^ c;

        if (gi < 7) begin : gGroupGp
            assign grpG[gi] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
                              (p[3] & p[2] & p[1] & g[0]);
            assign grpP[gi] = &p;
        end
    end

    // Second level: each group carry as a sum of products over lower groups
    always_comb begin : carryLookahead
        logic reach;
        logic span;
        grpCarry[0] = cin;
        for (int i = 1; i < 8; i++) begin
            reach = 1'b0;
            span  = 1'b1;
            // Walk down from group i-1, widening the propagate chain
            for (int j = 6; j >= 0; j--) begin
                if (j < i) begin
                    reach = reach | (span & grpG[j]);
                    span  = span & grpP[j];
                end
            end
            grpCarry[i] = reach | (span & cin);
        end
    end

endmodule

//--- execute/alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOpE       op,
    output logic [31:0] result,
    output logic        isTaken
);

    logic [4:0] shAmt;
    logic       isZero;
    logic       isNeg;

    // Only the low five bits matter for a 32-bit shift
    assign shAmt = b[4:0];

    // Branch compares look at a alone
    assign isZero = (a == '0);
    assign isNeg  = a[31];

    always_comb begin
        result  = '0;
        isTaken = 1'b0;
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSll:   result = a << shAmt;
            aluSrl:   result = a >> shAmt;
            // Signed compare, one in the LSB when a < b
            aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
            aluPassB: result = b;
            // Upper half from a, low half from the zero extended immediate
            aluSlbi:  result = (a << 16) | b;
            aluEqz:   isTaken = isZero;
            aluNez:   isTaken = !isZero;
            aluLtz:   isTaken = isNeg;
            aluGez:   isTaken = !isNeg;
            default: begin
                result  = '0;
                isTaken = 1'b0;
            end
        endcase
    end

endmodule

//--- execute/executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic [31:0] instr,
    input  logic [31:0] pcPlus1,
    input  logic [31:0] read1Data,
    input  logic [31:0] read2Data,
    input  logic        isSignExtend,
    input  logic        isIType1,
    input  logic        isBranch,
    input  logic        aluSrc,
    input  logic        isJump,
    input  logic        isJR,
    input  logic        isSLBI,
    input  aluOpE       aluOp,
    output logic [31:0] nextPC,
    output logic [31:0] aluResult
);

    logic [31:0] extImm1;
    logic [31:0] extImm2;
    logic [31:0] immValue;
    logic [31:0] pcOffset;
    logic [31:0] targetPC;
    logic [31:0] aluB;
    logic        isTaken;

    // IType1: signed 19 bits or zero extended 20 bits
    assign extImm1 = isSignExtend ?
        {{(32-imm1SignedW){instr[imm1SignedW-1]}}, instr[imm1SignedW-1:0]} :
        {{(32-imm1ZeroW){1'b0}}, instr[imm1ZeroW-1:0]};

    // IType2: SLBI zero extends 16 bits, the rest sign extend 23 bits
    assign extImm2 = isSLBI ?
        {{(32-slbiImmW){1'b0}}, instr[slbiImmW-1:0]} :
        {{(32-imm2SignedW){instr[imm2SignedW-1]}}, instr[imm2SignedW-1:0]};

    assign immValue = isIType1 ? extImm1 : extImm2;

    // Branches use the IType2 immediate, J/JAL the long displacement
    assign pcOffset = isBranch ? immValue :
        {{(32-jumpDispW){instr[jumpDispW-1]}}, instr[jumpDispW-1:0]};

    // R-type takes the second register, everything else the immediate
    assign aluB = aluSrc ? read2Data : immValue;

    claAdder32 iTargetAdder (
        .a   (pcOffset),
        .b   (pcPlus1),
        .cin (1'b0),
        .sum (targetPC)
    );

    alu iAlu (
        .a       (read1Data),
        .b       (aluB),
        .op      (aluOp),
        .result  (aluResult),
        .isTaken (isTaken)
    );

    // JR/JALR win over the relative target
    assign nextPC = isJR ? aluResult :
                    ((isBranch && isTaken) || isJump) ? targetPC : pcPlus1;

endmodule

//--- design/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int dmemDepth = 64
) (
    input  logic        clk,
    input  logic        wrEn,
    input  logic [31:0] addr,
    input  logic [31:0] wrData,
    output logic [31:0] rdData
);

    localparam int idxW = (dmemDepth > 1) ? $clog2(dmemDepth) : 1;

    logic [31:0]     mem [dmemDepth];
    logic [idxW-1:0] idx;

    // Word addressed, upper address bits are ignored
    assign idx = addr[idxW-1:0];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[idx] <= wrData;
        end
    end

    // Combinational read, old data during a write to the same word
    assign rdData = mem[idx];

    // A store past the end would silently alias a lower word
    assert property (@(posedge clk) wrEn |-> (addr < 32'(dmemDepth)))
        else $error("dataMemory: write to 0x%08h beyond depth %0d", addr, dmemDepth);

endmodule

//--- design/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; #(
    parameter int dmemDepth = 64
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic [31:0]         instr,
    output logic [31:0]         pc,
    output logic                regWrEn,
    output logic [regAddrW-1:0] regWrAddr,
    output logic [31:0]         regWrData,
    output logic                memWrEn,
    output logic [31:0]         memAddr,
    output logic [31:0]         memWrData,
    output logic                halted
);

    logic        isSignExtend, isIType1, isBranch, aluSrc, isJump, isJR, isSLBI;
    logic        regWrite, memWrite, memToReg, isLink, isHalt;
    aluOpE       aluOp;
    logic [31:0] pcPlus1, nextPC, aluResult;
    logic [31:0] read1Data, read2Data, memRdData;
    logic [regAddrW-1:0] rdAddr1, rdAddr2;
    logic        useFirstField;

    assign pcPlus1 = pc + 32'd1;

    // PC stops on HALT itself, so it keeps pointing at the HALT word
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            halted <= isHalt;
            if (!isHalt) begin
                pc <= nextPC;
            end
        end
    end

    controlUnit iControl (
        .opcode(opcodeE'(instr[opcodeMsb:opcodeLsb])), .isSignExtend(isSignExtend),
        .isIType1(isIType1), .isBranch(isBranch), .aluSrc(aluSrc), .isJump(isJump),
        .isJR(isJR), .isSLBI(isSLBI), .aluOp(aluOp), .regWrite(regWrite),
        .memWrite(memWrite), .memToReg(memToReg), .isLink(isLink), .isHalt(isHalt)
    );

    // Branches, JR/JALR, SLBI and the ST base read the first field
    assign useFirstField = isBranch | isJR | isSLBI | memWrite;
    assign rdAddr1 = useFirstField ? instr[reg1Lsb +: regAddrW] : instr[reg2Lsb +: regAddrW];
    // Store data comes from the second field, R-type B from the third
    assign rdAddr2 = memWrite ? instr[reg2Lsb +: regAddrW] : instr[reg3Lsb +: regAddrW];

    regFile iRegFile (
        .clk(clk), .rstN(rstN), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2), .wrEn(regWrEn),
        .wrAddr(regWrAddr), .wrData(regWrData), .rdData1(read1Data), .rdData2(read2Data)
    );

    executeStage iExecute (
        .instr(instr), .pcPlus1(pcPlus1), .read1Data(read1Data), .read2Data(read2Data),
        .isSignExtend(isSignExtend), .isIType1(isIType1), .isBranch(isBranch),
        .aluSrc(aluSrc), .isJump(isJump), .isJR(isJR), .isSLBI(isSLBI), .aluOp(aluOp),
        .nextPC(nextPC), .aluResult(aluResult)
    );

    dataMemory #(.dmemDepth(dmemDepth)) iDataMem (
        .clk(clk), .wrEn(memWrEn), .addr(memAddr), .wrData(memWrData), .rdData(memRdData)
    );

    // No writes out of reset or once halted
    assign regWrEn   = regWrite && rstN && !halted;
    assign memWrEn   = memWrite && rstN && !halted;
    assign regWrAddr = isLink ? linkReg : instr[reg1Lsb +: regAddrW];
    // Link return address, else load data, else ALU
    assign regWrData = isLink ? pcPlus1 : (memToReg ? memRdData : aluResult);
    assign memAddr   = aluResult;
    assign memWrData = read2Data;

endmodule

//--- dv/tbCpuCore.sv
`timescale 1ns/1ps

module tbCpuCore import cpuPkg::*; ();

    localparam int dmemDepth = 64;
    localparam int dmemAw    = $clog2(dmemDepth);
    localparam int imemAw    = 8;
    localparam int randCount = 64;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        regWrEn;
    logic [2:0]  regWrAddr;
    logic [31:0] regWrData;
    logic        memWrEn;
    logic [31:0] memAddr;
    logic [31:0] memWrData;
    logic        halted;

    // Instruction memory played by the testbench
    logic [31:0] imem [2**imemAw];
    int          progLen;
    int          cycleCount;
    int          limit;
    int          errorCount;
    int          timeoutCount;
    integer      seed = 52207;

    // Golden model state
    logic [31:0] mPc;
    logic        mHalted;
    logic [31:0] mRegs [8];
    logic [31:0] mMem [dmemDepth];

    // Golden model view of the current instruction
    opcodeE      op;
    logic [31:0] srcA, srcB, srcF, ldAddr;
    logic [31:0] sImm1, zImm1, sImm2, zImm2, sDisp;
    logic        expRegWrEn, expMemWrEn, expHalt;
    logic [2:0]  expRegWrAddr;
    logic [31:0] expRegWrData, expMemAddr, expMemWrData, expNextPc;

    cpuCore #(.dmemDepth(dmemDepth)) cpuCore_inst (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .regWrEn(regWrEn),
        .regWrAddr(regWrAddr), .regWrData(regWrData), .memWrEn(memWrEn),
        .memAddr(memAddr), .memWrData(memWrData), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rTypeWord(opcodeE o, logic [2:0] rd, logic [2:0] ra,
                                              logic [2:0] rb);
        return {o, rd, ra, rb, 18'b0};
    endfunction

    // IType1 holds first field, second field, an unused bit 20 and a 20-bit immediate
    function automatic logic [31:0] twoRegImmWord(opcodeE o, logic [2:0] r1, logic [2:0] r2,
                                                  logic [19:0] imm);
        return {o, r1, r2, 1'b0, imm};
    endfunction

    function automatic logic [31:0] oneRegImmWord(opcodeE o, logic [2:0] r1,
                                                  logic [22:0] imm);
        return {o, r1, 1'b0, imm};
    endfunction

    function automatic logic [31:0] jumpWord(opcodeE o, logic [26:0] disp);
        return {o, disp};
    endfunction

    function automatic logic [31:0] plainWord(opcodeE o);
        return {o, 27'b0};
    endfunction

    function automatic int draw(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic put(logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        int          loopTop;
        int          pick;
        logic [31:0] rnd;
        opcodeE      aluOps [12];
        opcodeE      branchOps [4];
        aluOps    = '{opAdd, opSub, opAnd, opOr, opXor, opSll, opSrl, opSlt,
                      opAddi, opAndi, opOri, opXori};
        branchOps = '{opBeqz, opBnez, opBltz, opBgez};
        // Anything past the program lands on HALT
        for (int i = 0; i < 2**imemAw; i++) begin
            imem[i] = plainWord(opHalt);
        end
        progLen = 0;
        // First reads see the cleared register file
        put(rTypeWord(opAdd, 3'd1, 3'd2, 3'd3));
        put(rTypeWord(opOr, 3'd4, 3'd5, 3'd6));
        // Sign versus zero extension
        put(twoRegImmWord(opAddi, 3'd1, 3'd0, 20'(-5)));
        put(twoRegImmWord(opAddi, 3'd2, 3'd0, 20'd100));
        put(twoRegImmWord(opAndi, 3'd3, 3'd1, 20'hfffff));
        put(twoRegImmWord(opOri, 3'd4, 3'd2, 20'h80000));
        put(twoRegImmWord(opXori, 3'd5, 3'd1, 20'h0f0f0));
        put(twoRegImmWord(opAddi, 3'd6, 3'd0, 20'h40000));
        put(twoRegImmWord(opOri, 3'd6, 3'd0, 20'h40000));
        put(rTypeWord(opAdd, 3'd6, 3'd1, 3'd2));
        put(rTypeWord(opSub, 3'd7, 3'd2, 3'd1));
        put(rTypeWord(opAnd, 3'd6, 3'd3, 3'd4));
        put(rTypeWord(opXor, 3'd7, 3'd3, 3'd4));
        // Shift amount 35 keeps only its low five bits
        put(twoRegImmWord(opAddi, 3'd3, 3'd0, 20'd35));
        put(rTypeWord(opSll, 3'd5, 3'd2, 3'd3));
        put(rTypeWord(opSrl, 3'd6, 3'd1, 3'd3));
        put(rTypeWord(opSlt, 3'd7, 3'd1, 3'd2));
        put(rTypeWord(opSlt, 3'd7, 3'd2, 3'd1));
        // Write to r0 is dropped and then read back
        put(twoRegImmWord(opAddi, 3'd0, 3'd2, 20'd7));
        put(rTypeWord(opAdd, 3'd1, 3'd0, 3'd0));
        put(plainWord(opNop));
        // SLBI on top of a small constant
        put(twoRegImmWord(opAddi, 3'd4, 3'd0, 20'h01234));
        put(oneRegImmWord(opSlbi, 3'd4, 23'h00abcd));
        // Branches both taken and not taken
        put(oneRegImmWord(opBeqz, 3'd0, 23'd1));
        put(twoRegImmWord(opAddi, 3'd1, 3'd0, 20'h777));
        put(oneRegImmWord(opBnez, 3'd0, 23'd2));
        put(twoRegImmWord(opAddi, 3'd1, 3'd0, 20'(-1)));
        put(oneRegImmWord(opBltz, 3'd1, 23'd1));
        put(twoRegImmWord(opAddi, 3'd2, 3'd0, 20'h777));
        put(oneRegImmWord(opBgez, 3'd1, 23'd1));
        put(oneRegImmWord(opBgez, 3'd0, 23'd1));
        put(twoRegImmWord(opAddi, 3'd2, 3'd0, 20'h777));
        // Backward loop running three passes
        put(twoRegImmWord(opAddi, 3'd2, 3'd0, 20'd3));
        loopTop = progLen;
        put(twoRegImmWord(opAddi, 3'd2, 3'd2, 20'(-1)));
        put(oneRegImmWord(opBnez, 3'd2, 23'(loopTop - progLen - 1)));
        // Relative jumps that each skip one word
        put(jumpWord(opJ, 27'd1));
        put(twoRegImmWord(opAddi, 3'd3, 3'd0, 20'h777));
        put(jumpWord(opJal, 27'd1));
        put(twoRegImmWord(opAddi, 3'd3, 3'd0, 20'h777));
        // Register jumps go to base plus one and skip the word after them
        put(twoRegImmWord(opAddi, 3'd3, 3'd0, 20'(progLen + 2)));
        put(oneRegImmWord(opJr, 3'd3, 23'd1));
        put(twoRegImmWord(opAddi, 3'd4, 3'd0, 20'h777));
        put(twoRegImmWord(opAddi, 3'd5, 3'd0, 20'(progLen + 2)));
        put(oneRegImmWord(opJalr, 3'd5, 23'd1));
        put(twoRegImmWord(opAddi, 3'd4, 3'd0, 20'h777));
        // Store and load back through a nonzero base
        put(twoRegImmWord(opAddi, 3'd2, 3'd0, 20'd20));
        put(twoRegImmWord(opSt, 3'd2, 3'd4, 20'(-4)));
        put(twoRegImmWord(opLd, 3'd5, 3'd2, 20'(-4)));
        put(twoRegImmWord(opSt, 3'd2, 3'd1, 20'd5));
        put(twoRegImmWord(opLd, 3'd6, 3'd0, 20'd25));
        // Words 0..15 are filled so random loads never read an empty word
        for (int a = 0; a < 16; a++) begin
            put(twoRegImmWord(opAddi, 3'd6, 3'd0, 20'(a * 37 + 5)));
            put(twoRegImmWord(opSt, 3'd0, 3'd6, 20'(a)));
        end
        for (int k = 0; k < randCount; k++) begin
            rnd = $random(seed);
            case (draw(5))
                0, 1: begin
                    pick = draw(12);
                    if (pick < 8)
                        put(rTypeWord(aluOps[pick], 3'(draw(8)), 3'(draw(8)), 3'(draw(8))));
                    else
                        put(twoRegImmWord(aluOps[pick], 3'(draw(8)), 3'(draw(8)),
                                          rnd[19:0]));
                end
                2: put(oneRegImmWord(branchOps[draw(4)], 3'(draw(8)), 23'(draw(4))));
                3: put(twoRegImmWord(opLd, 3'(draw(8)), 3'd0, 20'(draw(16))));
                default: put(twoRegImmWord(opSt, 3'd0, 3'(draw(8)), 20'(draw(16))));
            endcase
        end
        put(plainWord(opHalt));
    endtask

    // Instruction fetch for the new pc
    always @(negedge clk) begin
        instr <= imem[pc[imemAw-1:0]];
    end

    assign op     = opcodeE'(instr[opcodeMsb:opcodeLsb]);
    assign srcF   = mRegs[instr[26:24]];
    assign srcA   = mRegs[instr[23:21]];
    assign srcB   = mRegs[instr[20:18]];
    assign sImm1  = {{13{instr[18]}}, instr[18:0]};
    assign zImm1  = {12'b0, instr[19:0]};
    assign sImm2  = {{9{instr[22]}}, instr[22:0]};
    assign zImm2  = {16'b0, instr[15:0]};
    assign sDisp  = {{5{instr[26]}}, instr[26:0]};
    assign ldAddr = srcA + sImm1;

    // Expected strobes and next pc for this instruction
    always_comb begin
        expRegWrEn   = op inside {opAdd, opSub, opAnd, opOr, opXor, opSll, opSrl, opSlt,
                                  opAddi, opAndi, opOri, opXori, opLd, opSlbi, opJal, opJalr};
        expRegWrAddr = instr[26:24];
        expRegWrData = '0;
        expMemWrEn   = 1'b0;
        expMemAddr   = '0;
        expMemWrData = '0;
        expNextPc    = mPc + 32'd1;
        expHalt      = 1'b0;
        case (op)
            opAdd:  expRegWrData = srcA + srcB;
            opSub:  expRegWrData = srcA - srcB;
            opAnd:  expRegWrData = srcA & srcB;
            opOr:   expRegWrData = srcA | srcB;
            opXor:  expRegWrData = srcA ^ srcB;
            opSll:  expRegWrData = srcA << srcB[4:0];
            opSrl:  expRegWrData = srcA >> srcB[4:0];
            opSlt:  expRegWrData = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            opAddi: expRegWrData = srcA + sImm1;
            opAndi: expRegWrData = srcA & zImm1;
            opOri:  expRegWrData = srcA | zImm1;
            opXori: expRegWrData = srcA ^ zImm1;
            opLd:   expRegWrData = mMem[ldAddr[dmemAw-1:0]];
            opSt: begin
                expMemWrEn   = 1'b1;
                expMemAddr   = srcF + sImm1;
                expMemWrData = srcA;
            end
            opSlbi: expRegWrData = (srcF << 16) | zImm2;
            opBeqz: if (srcF == 32'd0) expNextPc = mPc + 32'd1 + sImm2;
            opBnez: if (srcF != 32'd0) expNextPc = mPc + 32'd1 + sImm2;
            opBltz: if (srcF[31]) expNextPc = mPc + 32'd1 + sImm2;
            opBgez: if (!srcF[31]) expNextPc = mPc + 32'd1 + sImm2;
            opJr:   expNextPc = srcF + sImm2;
            opJ:    expNextPc = mPc + 32'd1 + sDisp;
            opJalr, opJal: begin
                expNextPc    = (op == opJal) ? mPc + 32'd1 + sDisp : srcF + sImm2;
                expRegWrAddr = linkReg;
                expRegWrData = mPc + 32'd1;
            end
            opHalt: begin
                expHalt   = 1'b1;
                expNextPc = mPc;
            end
            default: ;
        endcase
        // Nothing is written out of reset or once halted
        if (!rstN || mHalted) begin
            expRegWrEn = 1'b0;
            expMemWrEn = 1'b0;
        end
    end

    // Model retires one instruction per edge
    always @(posedge clk) begin
        if (!rstN) begin
            mPc     <= '0;
            mHalted <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                mRegs[i] <= '0;
            end
        end else if (!mHalted) begin
            if (expRegWrEn && (expRegWrAddr != 3'd0)) begin
                mRegs[expRegWrAddr] <= expRegWrData;
            end
            if (expMemWrEn) begin
                mMem[expMemAddr[dmemAw-1:0]] <= expMemWrData;
            end
            mPc     <= expNextPc;
            mHalted <= expHalt;
        end
    end

    always @(posedge clk) begin
        if (!rstN) cycleCount <= 0;
        else cycleCount <= cycleCount + 1;
    end

    task automatic logMismatch(string name, logic [31:0] got, logic [31:0] exp);
        errorCount++;
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    endtask

    task automatic reportViolation(string what);
        errorCount++;
        $display("Error at %0t: %s", $time, what);
    endtask

    pcMatch: assert property (@(posedge clk) disable iff (!rstN) pc == mPc)
        else logMismatch("pc", $sampled(pc), $sampled(mPc));
    haltedMatch: assert property (@(posedge clk) disable iff (!rstN) halted == mHalted)
        else logMismatch("halted", 32'($sampled(halted)), 32'($sampled(mHalted)));
    regWrEnMatch: assert property (@(posedge clk) disable iff (!rstN) regWrEn == expRegWrEn)
        else logMismatch("regWrEn", 32'($sampled(regWrEn)), 32'($sampled(expRegWrEn)));
    regWrAddrMatch: assert property (@(posedge clk) disable iff (!rstN)
        regWrEn |-> regWrAddr == expRegWrAddr)
        else logMismatch("regWrAddr", 32'($sampled(regWrAddr)), 32'($sampled(expRegWrAddr)));
    regWrDataMatch: assert property (@(posedge clk) disable iff (!rstN)
        regWrEn |-> regWrData == expRegWrData)
        else logMismatch("regWrData", $sampled(regWrData), $sampled(expRegWrData));
    memWrEnMatch: assert property (@(posedge clk) disable iff (!rstN) memWrEn == expMemWrEn)
        else logMismatch("memWrEn", 32'($sampled(memWrEn)), 32'($sampled(expMemWrEn)));
    memAddrMatch: assert property (@(posedge clk) disable iff (!rstN)
        memWrEn |-> memAddr == expMemAddr)
        else logMismatch("memAddr", $sampled(memAddr), $sampled(expMemAddr));
    memWrDataMatch: assert property (@(posedge clk) disable iff (!rstN)
        memWrEn |-> memWrData == expMemWrData)
        else logMismatch("memWrData", $sampled(memWrData), $sampled(expMemWrData));
    // Strobes stay low in reset and after halt
    resetQuiet: assert property (@(posedge clk) !rstN |-> !regWrEn && !memWrEn)
        else reportViolation("a write strobe was high during reset");
    haltQuiet: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !regWrEn && !memWrEn)
        else reportViolation("a write strobe was high after the core halted");

    initial begin
        rstN         = 1'b0;
        instr        = '0;
        errorCount   = 0;
        timeoutCount = 0;
        buildProgram();
        limit = progLen * 2 + 50;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        while (!halted && (cycleCount < limit)) @(negedge clk);
        if (!halted) begin
            timeoutCount = 1;
            $display("Timeout: the core never halted within %0d cycles", limit);
        end else begin
            // Frozen core gets a store and then an ALU write at its held pc
            imem[pc[imemAw-1:0]] = twoRegImmWord(opSt, 3'd0, 3'd1, 20'd3);
            repeat (3) @(negedge clk);
            imem[pc[imemAw-1:0]] = rTypeWord(opAdd, 3'd1, 3'd2, 3'd3);
            repeat (3) @(negedge clk);
        end
        $display("Check errors: %0d, timeouts: %0d, cycles: %0d",
                 errorCount, timeoutCount, cycleCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- cpuCore.f
common/cpuPkg.sv
design/controlUnit.sv
design/regFile.sv
execute/claAdder32.sv
execute/alu.sv
execute/executeStage.sv
design/dataMemory.sv
design/cpuCore.sv
dv/tbCpuCore.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the cpuCore testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tbCpuCore -Mdir obj_dir -o simCpuCore \
    -f cpuCore.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/simCpuCore)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
